// ==== hack_pkg.sv ====
`default_nettype none

package hack_pkg;

    // word and address widths of the Hack machine.
    localparam int HACK_WORD_BITS = 16;
    localparam int HACK_ADDR_BITS = 15;

    // the data RAM decodes only the low address bits, so higher addresses alias.
    localparam int HACK_RAM_ADDR_BITS = 10;
    localparam int HACK_RAM_WORDS = 1 << HACK_RAM_ADDR_BITS;

    typedef logic [HACK_WORD_BITS-1:0] hack_word_t;
    typedef logic [HACK_ADDR_BITS-1:0] hack_addr_t;

    // ALU control in instruction order, bits 11 down to 6 of a C-instruction.
    typedef struct packed {
        logic zx;
        logic nx;
        logic zy;
        logic ny;
        logic f;
        logic no;
    } hack_alu_ctrl_t;

    // zr is set for a zero result, ng for a negative one.
    typedef struct packed {
        logic zr;
        logic ng;
    } hack_alu_flags_t;

    // destination field, bits 5 down to 3.
    typedef struct packed {
        logic a;
        logic d;
        logic m;
    } hack_dest_t;

    // jump field, bits 2 down to 0.
    typedef struct packed {
        logic lt;
        logic eq;
        logic gt;
    } hack_jump_t;

endpackage

`default_nettype wire

// ==== hack_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module hack_alu (
    input  wire hack_pkg::hack_word_t      i_x,
    input  wire hack_pkg::hack_word_t      i_y,
    input  wire hack_pkg::hack_alu_ctrl_t  i_ctrl,
    output hack_pkg::hack_word_t           o_result,
    output hack_pkg::hack_alu_flags_t      o_flags
);

    import hack_pkg::*;

    hack_word_t x_zeroed;
    hack_word_t x_final;
    hack_word_t y_zeroed;
    hack_word_t y_final;
    hack_word_t core_out;
    hack_word_t result;

    // operand preparation for x.
    always_comb begin
        x_zeroed = i_ctrl.zx ? '0 : i_x;
        x_final  = i_ctrl.nx ? ~x_zeroed : x_zeroed;
    end

    // operand preparation for y.
    always_comb begin
        y_zeroed = i_ctrl.zy ? '0 : i_y;
        y_final  = i_ctrl.ny ? ~y_zeroed : y_zeroed;
    end

    // the f bit picks the adder over the bitwise and.
    always_comb begin
        if (i_ctrl.f) begin
            core_out = x_final + y_final;
        end else begin
            core_out = x_final & y_final;
        end
    end

    // a final inversion gives the negated and incremented forms, e.g. -x and x+1.
    always_comb begin
        result = i_ctrl.no ? ~core_out : core_out;
    end

    assign o_result = result;

    // flags come straight from the final result.
    assign o_flags.zr = (result == '0);
    assign o_flags.ng = result[HACK_WORD_BITS-1];

endmodule

`default_nettype wire

// ==== hack_cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module hack_cpu (
    input  wire                        clk,
    input  wire                        i_arst_n,
    input  wire hack_pkg::hack_word_t  i_instruction,
    input  wire hack_pkg::hack_word_t  i_in_m,
    output hack_pkg::hack_word_t       o_out_m,
    output logic                       o_write_m,
    output hack_pkg::hack_addr_t       o_address_m,
    output hack_pkg::hack_addr_t       o_pc
);

    import hack_pkg::*;

    logic            is_c;
    logic            sel_m;
    hack_alu_ctrl_t  alu_ctrl;
    hack_dest_t      dest;
    hack_jump_t      jump;

    hack_word_t      a_reg;
    hack_word_t      d_reg;
    hack_addr_t      pc_reg;
    hack_addr_t      pc_next;

    hack_word_t      alu_y;
    hack_word_t      alu_result;
    hack_alu_flags_t alu_flags;
    logic            take_jump;

    // the top bit marks a C-instruction; an A-instruction carries a 15-bit value.
    assign is_c     = i_instruction[HACK_WORD_BITS-1];
    assign sel_m    = i_instruction[12];
    assign alu_ctrl = hack_alu_ctrl_t'(i_instruction[11:6]);

    // an A-instruction must not store anywhere or jump.
    assign dest = is_c ? hack_dest_t'(i_instruction[5:3]) : '0;
    assign jump = is_c ? hack_jump_t'(i_instruction[2:0]) : '0;

    // the a-bit selects M over A as the second operand.
    assign alu_y = sel_m ? i_in_m : a_reg;

    hack_alu hack_alu_i (
        .i_x      (d_reg),
        .i_y      (alu_y),
        .i_ctrl   (alu_ctrl),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    // positive means neither zero nor negative.
    always_comb begin
        take_jump = (jump.lt & alu_flags.ng)
                  | (jump.eq & alu_flags.zr)
                  | (jump.gt & ~alu_flags.zr & ~alu_flags.ng);
    end

    always_comb begin
        if (take_jump) begin
            pc_next = a_reg[HACK_ADDR_BITS-1:0];
        end else begin
            pc_next = pc_reg + hack_addr_t'(1);
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            a_reg <= '0;
        end else if (!is_c) begin
            a_reg <= i_instruction;
        end else if (dest.a) begin
            a_reg <= alu_result;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            d_reg <= '0;
        end else if (dest.d) begin
            d_reg <= alu_result;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_reg <= '0;
        end else begin
            pc_reg <= pc_next;
        end
    end

    // memory side; the write strobe stays low while the CPU is held in reset.
    assign o_out_m     = alu_result;
    assign o_write_m   = dest.m & i_arst_n;
    assign o_address_m = a_reg[HACK_ADDR_BITS-1:0];
    assign o_pc        = pc_reg;

    // the decoded destination must never let an A-instruction reach memory.
    a_instr_no_write: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !i_instruction[HACK_WORD_BITS-1] |-> !o_write_m
    ) else $error("memory write on an A-instruction");

    // execution restarts from address zero once reset is released.
    pc_zero_after_reset: assert property (
        @(posedge clk) $rose(i_arst_n) |-> (o_pc == '0)
    ) else $error("pc not zero on the first cycle after reset");

endmodule

`default_nettype wire

// ==== hack_data_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module hack_data_ram #(
    parameter int ADDR_BITS = hack_pkg::HACK_RAM_ADDR_BITS,
    parameter int WORDS     = hack_pkg::HACK_RAM_WORDS
) (
    input  wire                        clk,
    input  wire hack_pkg::hack_addr_t  i_addr,
    input  wire hack_pkg::hack_word_t  i_wdata,
    input  wire                        i_write,
    output hack_pkg::hack_word_t       o_rdata
);

    import hack_pkg::*;

    hack_word_t           mem [WORDS];
    logic [ADDR_BITS-1:0] index;

    // only the low bits are decoded, so the upper address space aliases.
    assign index = i_addr[ADDR_BITS-1:0];

    // asynchronous read feeds M back into the CPU within the same cycle.
    assign o_rdata = mem[index];

    always_ff @(posedge clk) begin
        if (i_write) begin
            mem[index] <= i_wdata;
        end
    end

    // a write to an unknown address would corrupt an arbitrary word.
    write_addr_known: assert property (
        @(posedge clk) i_write |-> !$isunknown(i_addr)
    ) else $error("data RAM write with unknown address");

endmodule

`default_nettype wire

// ==== hack_system.sv ====
`default_nettype none
`timescale 1ns/1ps

module hack_system (
    input  wire                        clk,
    input  wire                        i_arst_n,
    input  wire hack_pkg::hack_word_t  i_instruction,
    output hack_pkg::hack_word_t       o_out_m,
    output logic                       o_write_m,
    output hack_pkg::hack_addr_t       o_address_m,
    output hack_pkg::hack_addr_t       o_pc
);

    import hack_pkg::*;

    hack_word_t in_m;
    hack_word_t out_m;
    hack_addr_t address_m;
    logic       write_m;

    hack_cpu hack_cpu_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_instruction (i_instruction),
        .i_in_m        (in_m),
        .o_out_m       (out_m),
        .o_write_m     (write_m),
        .o_address_m   (address_m),
        .o_pc          (o_pc)
    );

    // the RAM sees the same address and data that leave the chip.
    hack_data_ram #(
        .ADDR_BITS (HACK_RAM_ADDR_BITS),
        .WORDS     (HACK_RAM_WORDS)
    ) hack_data_ram_i (
        .clk     (clk),
        .i_addr  (address_m),
        .i_wdata (out_m),
        .i_write (write_m),
        .o_rdata (in_m)
    );

    assign o_out_m     = out_m;
    assign o_write_m   = write_m;
    assign o_address_m = address_m;

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    // free-running clock that starts low, so the first rising edge falls at half a period.
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// ==== hack_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module hack_tb;

    import hack_pkg::*;

    localparam int RUN_INSTRUCTIONS = 3000;
    localparam int RESET_CYCLES     = 4;
    localparam int CYCLE_LIMIT      = RUN_INSTRUCTIONS + 2 * RESET_CYCLES + 100;
    localparam int DRIVE_DELAY      = 2;

    // the eighteen legal comp codes of the Hack instruction set.
    localparam logic [5:0] COMP_CODES [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };

    logic       clk;
    logic       arst_n;
    hack_word_t instruction;
    hack_word_t out_m;
    logic       write_m;
    hack_addr_t address_m;
    hack_addr_t pc;

    hack_word_t  model_a;
    hack_word_t  model_d;
    hack_addr_t  model_pc;
    hack_word_t  model_ram [HACK_RAM_WORDS];
    logic        ram_written [HACK_RAM_WORDS];
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS (40)
    ) tb_clock_gen_i (
        .o_clk (clk)
    );

    hack_system hack_system_i (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_instruction (instruction),
        .o_out_m       (out_m),
        .o_write_m     (write_m),
        .o_address_m   (address_m),
        .o_pc          (pc)
    );

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // results follow the Hack computation table, with x as D and y as A or M.
    function automatic hack_word_t model_alu(input logic [5:0] comp, input hack_word_t x,
                                             input hack_word_t y);
        case (comp)
            6'b101010: return 16'h0000;
            6'b111111: return 16'h0001;
            6'b111010: return 16'hffff;
            6'b001100: return x;
            6'b110000: return y;
            6'b001101: return ~x;
            6'b110001: return ~y;
            6'b001111: return -x;
            6'b110011: return -y;
            6'b011111: return x + 16'd1;
            6'b110111: return y + 16'd1;
            6'b001110: return x - 16'd1;
            6'b110010: return y - 16'd1;
            6'b000010: return x + y;
            6'b010011: return x - y;
            6'b000111: return y - x;
            6'b000000: return x & y;
            6'b010101: return x | y;
            default:   return 'x;
        endcase
    endfunction

    function automatic logic model_jump(input logic [2:0] jump, input hack_word_t result);
        logic zero;
        logic neg;
        zero = (result == 16'h0000);
        neg  = result[15];
        return (jump[2] && neg) || (jump[1] && zero) || (jump[0] && !zero && !neg);
    endfunction

    task automatic random_a_instruction(output hack_word_t instr);
        logic [31:0] bits;
        take_bits(10, bits);
        instr = {6'b000000, bits[9:0]};
    endtask

    task automatic random_c_instruction(output hack_word_t instr);
        logic [31:0] bits;
        logic [5:0]  comp;
        logic        a_bit;
        int          idx;
        take_bits(8, bits);
        idx  = int'(bits[7:0]) % 18;
        comp = COMP_CODES[idx];
        take_bits(1, bits);
        a_bit = bits[0];
        // the RAM starts undefined, so M is only used once its word has been stored.
        if (!ram_written[int'(model_a[HACK_RAM_ADDR_BITS-1:0])]) begin
            a_bit = 1'b0;
        end
        take_bits(6, bits);
        instr = {3'b111, a_bit, comp, bits[5:0]};
    endtask

    task automatic report_mismatch(input string what, input hack_word_t expected,
                                   input hack_word_t got);
        error_count++;
        $display("[ERROR] %0t ns: %s expected %h got %h", $time, what, expected, got);
    endtask

    task automatic check_outputs(input hack_word_t instr);
        logic       exp_write;
        hack_word_t y;
        hack_word_t exp_out;
        exp_write = instr[15] & instr[3];
        check_count += 3;
        if (pc !== model_pc) begin
            report_mismatch("pc", {1'b0, model_pc}, {1'b0, pc});
        end
        if (address_m !== model_a[14:0]) begin
            report_mismatch("address_m", {1'b0, model_a[14:0]}, {1'b0, address_m});
        end
        if (write_m !== exp_write) begin
            report_mismatch("write_m", {15'd0, exp_write}, {15'd0, write_m});
        end
        if (instr[15]) begin
            y = instr[12] ? model_ram[int'(model_a[HACK_RAM_ADDR_BITS-1:0])] : model_a;
            exp_out = model_alu(instr[11:6], model_d, y);
            check_count++;
            if (out_m !== exp_out) begin
                report_mismatch("out_m", exp_out, out_m);
            end
        end
    endtask

    task automatic advance_model(input hack_word_t instr);
        hack_word_t y;
        hack_word_t result;
        int         idx;
        idx = int'(model_a[HACK_RAM_ADDR_BITS-1:0]);
        if (!instr[15]) begin
            model_a  = instr;
            model_pc = model_pc + 15'd1;
        end else begin
            y = instr[12] ? model_ram[idx] : model_a;
            result = model_alu(instr[11:6], model_d, y);
            // the jump target and the store address both use A from before the edge.
            if (model_jump(instr[2:0], result)) begin
                model_pc = model_a[14:0];
            end else begin
                model_pc = model_pc + 15'd1;
            end
            if (instr[3]) begin
                model_ram[idx]   = result;
                ram_written[idx] = 1'b1;
            end
            if (instr[5]) begin
                model_a = result;
            end
            if (instr[4]) begin
                model_d = result;
            end
        end
    endtask

    task automatic execute(input hack_word_t instr);
        @(posedge clk);
        #(DRIVE_DELAY);
        arst_n      = 1'b1;
        instruction = instr;
        @(negedge clk);
        check_outputs(instr);
        advance_model(instr);
    endtask

    task automatic hold_reset(input int cycles);
        hack_word_t instr;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            arst_n   = 1'b0;
            model_a  = '0;
            model_d  = '0;
            model_pc = '0;
            // an M destination during reset shows that the write strobe is held off.
            random_c_instruction(instr);
            instruction = instr | 16'h0008;
            @(negedge clk);
            check_count += 3;
            if (pc !== 15'd0) begin
                report_mismatch("pc in reset", 16'h0000, {1'b0, pc});
            end
            if (address_m !== 15'd0) begin
                report_mismatch("address_m in reset", 16'h0000, {1'b0, address_m});
            end
            if (write_m !== 1'b0) begin
                report_mismatch("write_m in reset", 16'h0000, {15'd0, write_m});
            end
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0] bits;
        hack_word_t  instr;
        for (int i = 0; i < count; i++) begin
            take_bits(8, bits);
            if (bits[7:0] % 5 < 2) begin
                random_a_instruction(instr);
            end else begin
                random_c_instruction(instr);
            end
            execute(instr);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        instruction = '0;
        lfsr_state  = 32'hfe8b;
        error_count = 0;
        check_count = 0;
        model_a     = '0;
        model_d     = '0;
        model_pc    = '0;
        for (int i = 0; i < HACK_RAM_WORDS; i++) begin
            model_ram[i]   = '0;
            ram_written[i] = 1'b0;
        end
        hold_reset(RESET_CYCLES);
        run_random(RUN_INSTRUCTIONS / 2);
        hold_reset(RESET_CYCLES);
        // comp D with no destination exposes D on out_m right after reset.
        execute(16'he300);
        run_random(RUN_INSTRUCTIONS / 2 - 1);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hack_pkg.sv
hack_alu.sv
hack_cpu.sv
hack_data_ram.sv
hack_system.sv
tb_clock_gen.sv
hack_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := hack_tb
FILELIST := compile.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
